//--- Makefile
TOP = tb_mrd_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f hw/*.sv sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

//--- filelist.f
hw/mrd_pkg.sv
hw/mrd_apb_regs.sv
hw/mrd_addr_gen.sv
hw/mrd_bank_rd.sv
hw/mrd_bank_mem.sv
hw/mrd_top.sv
sim/tb_clkgen.sv
sim/tb_mrd_top.sv

//--- hw/mrd_addr_gen.sv
`timescale 1ns/1ns

module mrd_addr_gen import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  stage_cfg_t cfg,
	input  logic       start,
	output logic       req_valid,
	output lane_addr_t req
);

	stage_cfg_t cfg_q;
	logic run;
	logic is_last;
	logic [ADDR_W-1:0] bfly_cnt;
	logic [ADDR_W-1:0] offset;
	logic [ADDR_W-1:0] base;
	logic [ADDR_W-1:0] lane_sum [NUM_LANES];

	// base + m*stride as a chain of adds
	always_comb
	begin
		lane_sum[0] = base;
		for (int m = 1; m < NUM_LANES; m++)
			lane_sum[m] = lane_sum[m-1] + cfg_q.stride;
	end

	assign is_last = (bfly_cnt == cfg_q.bfly_count - 1'b1);

	// ----------------------------------------
	// butterfly walk
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			run      <= 1'b0;
			bfly_cnt <= '0;
			offset   <= '0;
			base     <= '0;
			cfg_q    <= '0;
		end
		else if (start)
		begin
			run      <= 1'b1;
			bfly_cnt <= '0;
			offset   <= '0;
			base     <= '0;
			cfg_q    <= cfg;
		end
		else if (run)
		begin
			run      <= ~is_last;
			bfly_cnt <= bfly_cnt + 1'b1;
			if (offset == cfg_q.stride - 1'b1)
			begin
				// next group starts one past the top lane of this one
				offset <= '0;
				base   <= lane_sum[cfg_q.radix - 3'd1] + 1'b1;
			end
			else
			begin
				offset <= offset + 1'b1;
				base   <= base + 1'b1;
			end
		end
	end

	always_comb
	begin
		req_valid = run;
		req.last  = is_last;
		for (int m = 0; m < NUM_LANES; m++)
		begin
			req.active[m] = (3'(m) < cfg_q.radix);
			req.addr[m]   = req.active[m] ? lane_sum[m] : '0;
		end
	end

endmodule

//--- hw/mrd_apb_regs.sv
`timescale 1ns/1ns

module mrd_apb_regs import mrd_pkg::*;
#(
	parameter int ROW_W = 6
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [PADDR_W-1:0] paddr,
	input  logic [PDATA_W-1:0] pwdata,
	output logic [PDATA_W-1:0] prdata,
	output logic               pready,
	output logic               pslverr,
	output stage_cfg_t         cfg,
	output logic               start,
	input  logic               pass_end,
	output logic               mem_we,
	output logic [ADDR_W-1:0]  mem_addr,
	output sample_t            mem_wdata,
	input  sample_t            mem_rdata
);

	localparam int MEM_BYTES = 4 * NUM_BANKS * (2 ** ROW_W);

	logic access;
	logic wr_en;
	logic is_ctrl, is_radix, is_stride, is_count, is_status;
	logic in_mem;
	logic start_req;
	logic busy, done;
	logic [PADDR_W-1:0] mem_off;

	// ----------------------------------------
	// decode
	// ----------------------------------------
	assign access    = psel & penable;
	assign wr_en     = access & pwrite;
	assign is_ctrl   = (paddr == REG_CTRL);
	assign is_radix  = (paddr == REG_CFG_RADIX);
	assign is_stride = (paddr == REG_CFG_STRIDE);
	assign is_count  = (paddr == REG_CFG_COUNT);
	assign is_status = (paddr == REG_STATUS);
	assign in_mem    = (paddr >= MEM_BASE) && (paddr[1:0] == 2'b00) &&
		(int'(paddr) < int'(MEM_BASE) + MEM_BYTES);

	assign start_req = wr_en & is_ctrl & pwdata[0] & ~busy;

	assign pready  = 1'b1;
	assign pslverr = access & (~(is_ctrl | is_radix | is_stride | is_count | is_status | in_mem)
		| (in_mem & busy) | (pwrite & is_ctrl & pwdata[0] & busy));

	// memory window, one sample per word
	assign mem_off   = paddr - MEM_BASE;
	assign mem_addr  = mem_off[ADDR_W+1:2];
	assign mem_we    = wr_en & in_mem & ~busy;
	assign mem_wdata = pwdata;

	always_comb
	begin
		prdata = '0;
		if (is_radix)
			prdata[2:0] = cfg.radix;
		else if (is_stride)
			prdata[ADDR_W-1:0] = cfg.stride;
		else if (is_count)
			prdata[ADDR_W-1:0] = cfg.bfly_count;
		else if (is_status)
			prdata[1:0] = {done, busy};
		else if (in_mem && !busy)
			prdata = mem_rdata;
	end

	// ----------------------------------------
	// registers and pass flags
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			start <= 1'b0;
			busy  <= 1'b0;
			done  <= 1'b0;
			cfg   <= '0;
		end
		else
		begin
			start <= start_req;
			if (start_req)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (pass_end)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (wr_en && is_radix)
				cfg.radix <= pwdata[2:0];
			if (wr_en && is_stride)
				cfg.stride <= pwdata[ADDR_W-1:0];
			if (wr_en && is_count)
				cfg.bfly_count <= pwdata[ADDR_W-1:0];
		end
	end

	// a pass ends only while busy and never on top of a new start
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		pass_end |-> (busy && !start));
	a_start_radix: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (cfg.radix >= 3'd2 && cfg.radix <= 3'd5));

endmodule

//--- hw/mrd_bank_mem.sv
`timescale 1ns/1ns

module mrd_bank_mem import mrd_pkg::*;
#(
	parameter int ROW_W = 6
)
(
	input  logic                        clk,
	input  logic [bank_rd_w(ROW_W)-1:0] bank_rd,
	input  logic                        we,
	input  logic [ADDR_W-1:0]           waddr,
	input  sample_t                     wdata,
	input  logic [ADDR_W-1:0]           raddr,
	output sample_t                     apb_rdata,
	output sample_t [NUM_BANKS-1:0]     bank_dout
);

	typedef struct packed {
		logic [NUM_BANKS-1:0]            rden;
		logic [NUM_BANKS-1:0][ROW_W-1:0] row;
	} bank_rd_t;

	localparam int DEPTH = 2 ** ROW_W;

	bank_rd_t rd;
	logic [2:0] wbank, rbank;
	logic [ROW_W-1:0] wrow, rrow;
	sample_t apb_word [NUM_BANKS];

	assign rd = bank_rd;

	// linear sample address to bank and row
	assign wbank = mod7(waddr);
	assign wrow  = ROW_W'(div7(waddr));
	assign rbank = mod7(raddr);
	assign rrow  = ROW_W'(div7(raddr));

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		sample_t ram [DEPTH];
		sample_t dout_q;

		always_ff @(posedge clk)
		begin
			if (we && wbank == 3'(b))
				ram[wrow] <= wdata;
			if (rd.rden[b])
				dout_q <= ram[rd.row[b]];
		end

		assign bank_dout[b] = dout_q;
		assign apb_word[b]  = ram[rrow];
	end

	assign apb_rdata = apb_word[rbank];

	a_no_wr_in_pass: assert property (@(posedge clk) !(we && (|rd.rden)));

endmodule

//--- hw/mrd_bank_rd.sv
`timescale 1ns/1ns

module mrd_bank_rd import mrd_pkg::*;
#(
	parameter int ROW_W = 6
)
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          req_valid,
	input  lane_addr_t                    req,
	output logic [bank_rd_w(ROW_W)-1:0]   bank_rd,
	input  sample_t [NUM_BANKS-1:0]       bank_dout,
	output rd_beat_t                      beat,
	output logic                          pass_end
);

	typedef struct packed {
		logic [NUM_BANKS-1:0]            rden;
		logic [NUM_BANKS-1:0][ROW_W-1:0] row;
	} bank_rd_t;

	// index 7 marks a lane with no bank
	localparam logic [2:0] NO_BANK = 3'd7;

	logic [NUM_LANES-1:0][2:0]       idx1, idx2, idx3;
	logic [NUM_LANES-1:0][ROW_W-1:0] row1;
	logic v1, v2, v3;
	logic last1, last2, last3;
	logic [NUM_BANKS-1:0]            bank_hit, rden_q;
	logic [NUM_BANKS-1:0][ROW_W-1:0] bank_row, row_q;
	logic bank_clash;
	bank_rd_t rd_s;

	// ----------------------------------------
	// stage 1: bank mapping
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v1    <= 1'b0;
			last1 <= 1'b0;
			idx1  <= {NUM_LANES{NO_BANK}};
		end
		else
		begin
			v1    <= req_valid;
			last1 <= req_valid & req.last;
			for (int m = 0; m < NUM_LANES; m++)
				idx1[m] <= (req_valid && req.active[m]) ? mod7(req.addr[m]) : NO_BANK;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int m = 0; m < NUM_LANES; m++)
			row1[m] <= ROW_W'(div7(req.addr[m]));
	end

	// ----------------------------------------
	// stage 2: read issue
	// ----------------------------------------
	always_comb
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			bank_hit[b] = 1'b0;
			bank_row[b] = '0;
			for (int m = NUM_LANES - 1; m >= 0; m--)
			begin
				if (idx1[m] == 3'(b))
				begin
					bank_hit[b] = 1'b1;
					bank_row[b] = row1[m];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rden_q <= '0;
			v2     <= 1'b0;
			v3     <= 1'b0;
			last2  <= 1'b0;
			last3  <= 1'b0;
			idx2   <= {NUM_LANES{NO_BANK}};
			idx3   <= {NUM_LANES{NO_BANK}};
		end
		else
		begin
			rden_q <= bank_hit;
			v2     <= v1;
			v3     <= v2;
			last2  <= last1;
			last3  <= last2;
			// index copies line up with the bank data register
			idx2   <= idx1;
			idx3   <= idx2;
		end
	end

	always_ff @(posedge clk)
	begin
		row_q <= bank_row;
	end

	assign rd_s.rden = rden_q;
	assign rd_s.row  = row_q;
	assign bank_rd   = rd_s;

	// ----------------------------------------
	// stage 3: data back into lane order
	// ----------------------------------------
	always_comb
	begin
		beat.valid = v3;
		beat.last  = last3;
		for (int m = 0; m < NUM_LANES; m++)
		begin
			beat.active[m] = (idx3[m] != NO_BANK);
			beat.lane[m]   = beat.active[m] ? bank_dout[idx3[m]] : '0;
		end
	end

	assign pass_end = v3 & last3;

	always_comb
	begin
		bank_clash = 1'b0;
		for (int m = 0; m < NUM_LANES; m++)
			for (int n = m + 1; n < NUM_LANES; n++)
				if (idx1[m] != NO_BANK && idx1[m] == idx1[n])
					bank_clash = 1'b1;
	end

	// stride must keep the active lanes apart
	a_no_clash: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |=> !bank_clash);

endmodule

//--- hw/mrd_pkg.sv
package mrd_pkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------
	localparam int NUM_BANKS = 7;
	localparam int NUM_LANES = 5;
	localparam int SAMPLE_W  = 16;
	localparam int ADDR_W    = 12;
	localparam int PADDR_W   = 16;
	localparam int PDATA_W   = 32;

	// divide by 7 as multiply and shift, exact for all ADDR_W inputs
	localparam int DIV7_MUL = 2341;
	localparam int DIV7_SH  = 14;

	// apb byte offsets
	localparam logic [PADDR_W-1:0] REG_CTRL       = 16'h0000;
	localparam logic [PADDR_W-1:0] REG_CFG_RADIX  = 16'h0004;
	localparam logic [PADDR_W-1:0] REG_CFG_STRIDE = 16'h0008;
	localparam logic [PADDR_W-1:0] REG_CFG_COUNT  = 16'h000C;
	localparam logic [PADDR_W-1:0] REG_STATUS     = 16'h0010;
	localparam logic [PADDR_W-1:0] MEM_BASE       = 16'h1000;

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] re;
		logic signed [SAMPLE_W-1:0] im;
	} sample_t;

	typedef struct packed {
		logic [NUM_LANES-1:0][ADDR_W-1:0] addr;
		logic [NUM_LANES-1:0]             active;
		logic                             last;
	} lane_addr_t;

	typedef struct packed {
		logic [2:0]        radix;
		logic [ADDR_W-1:0] stride;
		logic [ADDR_W-1:0] bfly_count;
	} stage_cfg_t;

	typedef struct packed {
		logic                 valid;
		logic                 last;
		logic [NUM_LANES-1:0] active;
		sample_t [NUM_LANES-1:0] lane;
	} rd_beat_t;

	// bank read request is rden[NUM_BANKS] in the upper bits, then
	// row[NUM_BANKS] of row_w bits each, bank 0 lowest
	function automatic int bank_rd_w(input int row_w);
		return NUM_BANKS * (row_w + 1);
	endfunction

	function automatic logic [ADDR_W-1:0] div7(input logic [ADDR_W-1:0] a);
		logic [2*ADDR_W-1:0] prod;
		prod = (2*ADDR_W)'(a) * (2*ADDR_W)'(DIV7_MUL);
		return ADDR_W'(prod >> DIV7_SH);
	endfunction

	function automatic logic [2:0] mod7(input logic [ADDR_W-1:0] a);
		logic [ADDR_W-1:0] q;
		q = div7(a);
		// a - 7q
		return 3'(a - (q << 3) + q);
	endfunction

endpackage

//--- hw/mrd_top.sv
`timescale 1ns/1ns

module mrd_top import mrd_pkg::*;
#(
	parameter int ROW_W = 6
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [PADDR_W-1:0] paddr,
	input  logic [PDATA_W-1:0] pwdata,
	output logic [PDATA_W-1:0] prdata,
	output logic               pready,
	output logic               pslverr,
	output rd_beat_t           beat
);

	// ----------------------------------------
	// internal wires
	// ----------------------------------------
	stage_cfg_t cfg;
	logic start;
	logic pass_end;
	logic mem_we;
	logic [ADDR_W-1:0] mem_addr;
	sample_t mem_wdata;
	sample_t mem_rdata;
	logic req_valid;
	lane_addr_t req;
	logic [bank_rd_w(ROW_W)-1:0] bank_rd;
	sample_t [NUM_BANKS-1:0] bank_dout;

	mrd_apb_regs #(
		.ROW_W (ROW_W)
	) u_apb_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cfg       (cfg),
		.start     (start),
		.pass_end  (pass_end),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	mrd_addr_gen u_addr_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.start     (start),
		.req_valid (req_valid),
		.req       (req)
	);

	mrd_bank_rd #(
		.ROW_W (ROW_W)
	) u_bank_rd (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.bank_rd   (bank_rd),
		.bank_dout (bank_dout),
		.beat      (beat),
		.pass_end  (pass_end)
	);

	// apb read and write share one linear address
	mrd_bank_mem #(
		.ROW_W (ROW_W)
	) u_bank_mem (
		.clk       (clk),
		.bank_rd   (bank_rd),
		.we        (mem_we),
		.waddr     (mem_addr),
		.wdata     (mem_wdata),
		.raddr     (mem_addr),
		.apb_rdata (mem_rdata),
		.bank_dout (bank_dout)
	);

endmodule

//--- sim/mrd_tests.txt
# one command per line, fields in hex
# W addr data | F addr count (random data) | R addr | S reg value | G reg expected
# E offset (pslverr) | P radix stride count | X radix stride count addr data
G 10 0
S 4 3
S 8 2a
S c 1f
G 4 3
G 8 2a
G c 1f
E 14
E 1002
E 1700
F 0 1c0
W 1b9 7fff8000
W 1ba 00017ffe
W 1bb 8001c0de
W 1bc 12345678
W 1bd fedc0123
W 1be 00000001
W 1bf 5a5aa5a5
R 0
R 1b9
R 1ba
R 1bb
R 1bc
R 1bd
R 1be
R 1bf
P 2 1 8
P 3 4 c
P 4 10 10
P 5 5 19
P 5 1 14
P 2 40 40
P 3 9 9
P 4 1 70
X 4 8 28 5 deadbeef
R 5
P 2 3 6
G 10 2

//--- sim/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen
#(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
)
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// release just after an edge so every reset cycle is seen whole
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

//--- sim/tb_mrd_top.sv
`timescale 1ns/1ns

module tb_mrd_top import mrd_pkg::*;
();

	localparam int ROW_W     = 6;
	localparam int MEM_WORDS = NUM_BANKS * (2 ** ROW_W);
	localparam int SEED      = 32'h22d8_5974;
	localparam int POLL_MAX  = 8;
	localparam string TEST_FILE = "sim/mrd_tests.txt";

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [PADDR_W-1:0] paddr;
	logic [PDATA_W-1:0] pwdata;
	logic [PDATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	rd_beat_t beat;

	logic [PDATA_W-1:0] mirror [MEM_WORDS];
	rd_beat_t beats [$];
	int cycle_count = 0;
	int cycle_limit = 0;

	tb_clkgen #(
		.PERIOD       (40),
		.RESET_CYCLES (2)
	) u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mrd_top #(
		.ROW_W (ROW_W)
	) u_mrd_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.beat    (beat)
	);

	// ----------------------------------------
	// beat monitor and run limit
	// ----------------------------------------
	always @(negedge clk)
	begin
		if (rst_n && beat.valid === 1'b1)
			beats.push_back(beat);
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("STATUS: FAIL");
			$fatal(1, "run aborted on timeout");
		end
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s, expected %h, got %h", $time, what,
				expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------
	// apb transfers, setup then access
	// ----------------------------------------
	task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [31:0] data,
		output logic err);
		@(posedge clk);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		err = pslverr;
		check_value("pready in write access", 32'h1, 32'(pready));
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [PADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge clk);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#2;
		penable = 1'b1;
		// prdata settles within the access cycle
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		check_value("pready in read access", 32'h1, 32'(pready));
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	function automatic logic [PADDR_W-1:0] mem_offset(input int a);
		return PADDR_W'(int'(MEM_BASE) + 4 * a);
	endfunction

	task automatic mem_write(input int a, input logic [31:0] data);
		logic err;
		apb_write(mem_offset(a), data, err);
		check_value($sformatf("pslverr on write of sample %0d", a), 32'h0, 32'(err));
		mirror[a] = data;
	endtask

	// ----------------------------------------
	// stage passes
	// ----------------------------------------
	task automatic setup_stage(input int radix, input int stride, input int count);
		logic err;
		apb_write(REG_CFG_RADIX, 32'(radix), err);
		check_value("pslverr on radix write", 32'h0, 32'(err));
		apb_write(REG_CFG_STRIDE, 32'(stride), err);
		check_value("pslverr on stride write", 32'h0, 32'(err));
		apb_write(REG_CFG_COUNT, 32'(count), err);
		check_value("pslverr on count write", 32'h0, 32'(err));
		beats.delete();
		apb_write(REG_CTRL, 32'h1, err);
		check_value("pslverr on start", 32'h0, 32'(err));
	endtask

	task automatic finish_pass(input int radix, input int stride, input int count);
		logic [31:0] status;
		logic [31:0] expected;
		logic err;
		int polls;
		int base;
		rd_beat_t b;
		while (beats.size() < count)
			@(posedge clk);
		polls  = 0;
		status = 32'h1;
		while (status[0] && polls < POLL_MAX)
		begin
			apb_read(REG_STATUS, status, err);
			check_value("pslverr on status read", 32'h0, 32'(err));
			polls++;
		end
		if (status[0])
		begin
			$display("busy still set after %0d status reads at the end of a pass", POLL_MAX);
			$display("STATUS: FAIL");
			$fatal(1, "pass did not end");
		end
		check_value("status after pass", 32'h2, status);
		check_value("beat count", 32'(count), 32'(beats.size()));
		for (int j = 0; j < count; j++)
		begin
			b    = beats[j];
			base = (j / stride) * stride * radix + (j % stride);
			check_value($sformatf("active mask of bfly %0d", j), (32'd1 << radix) - 1,
				32'(b.active));
			check_value($sformatf("last flag of bfly %0d", j), 32'(j == count - 1),
				32'(b.last));
			for (int m = 0; m < NUM_LANES; m++)
			begin
				expected = (m < radix) ? mirror[base + m * stride] : 32'h0;
				check_value($sformatf("bfly %0d lane %0d", j, m), expected, b.lane[m]);
			end
		end
	endtask

	// window and second start are refused while the pass runs
	task automatic busy_access(input int radix, input int stride, input int count,
		input int a, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		setup_stage(radix, stride, count);
		apb_write(mem_offset(a), data, err);
		check_value("pslverr on window write while busy", 32'h1, 32'(err));
		apb_write(REG_CTRL, 32'h1, err);
		check_value("pslverr on second start", 32'h1, 32'(err));
		apb_read(mem_offset(a), rdata, err);
		check_value("pslverr on window read while busy", 32'h1, 32'(err));
		apb_read(REG_STATUS, rdata, err);
		check_value("pslverr on status read during pass", 32'h0, 32'(err));
		check_value("status during pass", 32'h1, rdata);
		finish_pass(radix, stride, count);
	endtask

	// sum of the cycle budget over all test lines
	task automatic compute_limit();
		int fd;
		int total;
		string line;
		logic [31:0] a0, a1, a2, a3, a4;
		total = 0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open the test file %s", TEST_FILE);
			$display("STATUS: FAIL");
			$fatal(1, "no test file");
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
				a0, a1, a2, a3, a4));
			case (line.getc(0))
				"F": total += 4 * int'(a1);
				"P": total += 4 * 5 + int'(a2) + 20;
				"X": total += 4 * 9 + int'(a2) + 20;
				default: total += 4;
			endcase
		end
		$fclose(fd);
		cycle_limit = 2 * total;
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		int fd;
		string line;
		byte cmd;
		logic [31:0] a0, a1, a2, a3, a4;
		logic [31:0] data;
		logic err;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		void'($urandom(SEED));
		compute_limit();
		fd = $fopen(TEST_FILE, "r");
		@(posedge rst_n);
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			cmd = line.getc(0);
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
				a0, a1, a2, a3, a4));
			case (cmd)
				"W": mem_write(int'(a0), a1);
				"F":
				begin
					for (int i = 0; i < int'(a1); i++)
						mem_write(int'(a0) + i, $urandom());
				end
				"R":
				begin
					apb_read(mem_offset(int'(a0)), data, err);
					check_value("pslverr on window read", 32'h0, 32'(err));
					check_value($sformatf("readback of sample %0d", a0), mirror[a0], data);
				end
				"S":
				begin
					apb_write(a0[PADDR_W-1:0], a1, err);
					check_value("pslverr on register write", 32'h0, 32'(err));
				end
				"G":
				begin
					apb_read(a0[PADDR_W-1:0], data, err);
					check_value("pslverr on register read", 32'h0, 32'(err));
					check_value($sformatf("register %h", a0), a1, data);
				end
				"E":
				begin
					apb_read(a0[PADDR_W-1:0], data, err);
					check_value($sformatf("pslverr at offset %h", a0), 32'h1, 32'(err));
				end
				"P":
				begin
					setup_stage(int'(a0), int'(a1), int'(a2));
					finish_pass(int'(a0), int'(a1), int'(a2));
				end
				"X": busy_access(int'(a0), int'(a1), int'(a2), int'(a3), a4);
				default:
				begin
					$display("unknown command in the test file: %s", line);
					$display("STATUS: FAIL");
					$fatal(1, "bad test file");
				end
			endcase
		end
		$fclose(fd);
		$display("STATUS: PASS");
		$finish;
	end

endmodule
